// File: all.f
logic/id_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
verification/id_stage_tb.sv

// File: logic/branch_unit.sv
`default_nettype none

module branch_unit (
    input  wire id_pkg::decoded_t dec_i,
    input  wire id_pkg::word_t    pc_i,
    input  wire id_pkg::word_t    ra_i,
    input  wire id_pkg::word_t    rb_i,
    input  wire logic             hazard_i,
    output id_pkg::jump_t         jmp_o
);

logic cmp_w;
logic taken_w;

// funct3[2:1] picks the compare, funct3[0] negates it
always_comb begin
    case (dec_i.funct3[2:1])
        2'b00:   cmp_w = (ra_i == rb_i);
        2'b10:   cmp_w = ($signed(ra_i) < $signed(rb_i));
        2'b11:   cmp_w = (ra_i < rb_i);
        default: cmp_w = 1'b0;
    endcase
    taken_w = cmp_w ^ dec_i.funct3[0];
end

always_comb begin
    case (dec_i.ctrl.pc_mode)
        id_pkg::PC_JUMP_REL: begin
            jmp_o.valid = 1'b1;   // jal needs no register
            jmp_o.addr  = pc_i + dec_i.imm_j;
        end
        id_pkg::PC_JUMP_ABS: begin
            jmp_o.valid = !hazard_i;
            jmp_o.addr  = ra_i + dec_i.imm_i;
        end
        id_pkg::PC_BRANCH: begin
            jmp_o.valid = taken_w && !hazard_i;
            jmp_o.addr  = pc_i + dec_i.imm_b;
        end
        default: begin
            jmp_o.valid = 1'b0;
            jmp_o.addr  = '0;
        end
    endcase
end

endmodule

`default_nettype wire

// File: logic/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regaddr_t;

    // major opcodes of RV32I, SYSTEM left out on purpose
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP          = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111
    } opcode_e;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_e;

    typedef enum logic [1:0] {ALU_OP1_ZERO, ALU_OP1_RS1, ALU_OP1_IMMU} alu_op1_e;

    typedef enum logic [2:0] {
        ALU_OP2_ZERO, ALU_OP2_RS2, ALU_OP2_IMMI, ALU_OP2_IMMS, ALU_OP2_PC
    } alu_op2_e;

    // encoded as {funct7[0], funct7[5], funct3}
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SLL   = 5'b00001,
        ALU_SLT   = 5'b00010,
        ALU_SLTU  = 5'b00011,
        ALU_XOR   = 5'b00100,
        ALU_SRL   = 5'b00101,
        ALU_OR    = 5'b00110,
        ALU_AND   = 5'b00111,
        ALU_SUB   = 5'b01000,
        ALU_SRA   = 5'b01101,
        ALU_COPY1 = 5'b11111   // pass operand 1 through
    } alu_mode_e;

    typedef enum logic [1:0] {MA_NONE, MA_LOAD, MA_STORE} ma_mode_e;

    // straight from funct3 of loads and stores
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101
    } ma_size_e;

    typedef enum logic [1:0] {WB_SRC_NONE, WB_SRC_ALU, WB_SRC_MEM, WB_SRC_PC4} wb_src_e;

    typedef struct packed {
        logic      halt;
        pc_mode_e  pc_mode;
        alu_op1_e  alu_op1;
        alu_op2_e  alu_op2;
        alu_mode_e alu_mode;
        ma_mode_e  ma_mode;
        ma_size_e  ma_size;
        wb_src_e   wb_src;
        logic      ra_used;
        logic      rb_used;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        regaddr_t   rs1;
        regaddr_t   rs2;
        regaddr_t   rd;
        logic [2:0] funct3;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        regaddr_t addr;
        word_t    data;
    } reg_write_t;

    // in-flight result, ready once the data exists
    typedef struct packed {
        reg_write_t wr;
        logic       ready;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } jump_t;

    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_e alu_mode;
        ma_mode_e  ma_mode;
        ma_size_e  ma_size;
        word_t     ma_data;
        wb_src_e   wb_src;
        word_t     wb_data;
        logic      wb_valid;
        logic      halt;
    } id_out_t;

    localparam word_t NOP_IR = 32'h00000013;   // addi x0, x0, 0

endpackage

`default_nettype wire

// File: logic/id_stage.sv
`default_nettype none

module id_stage #(
    parameter id_pkg::word_t BUBBLE_PC = 32'h0
) (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire id_pkg::word_t      pc_i,
    input  wire id_pkg::word_t      ir_i,
    input  wire id_pkg::fwd_t       ex_fwd_i,
    input  wire id_pkg::fwd_t       ma_fwd_i,
    input  wire id_pkg::reg_write_t wb_i,
    output logic                    ready_o,
    output id_pkg::jump_t           jmp_o,
    output id_pkg::id_out_t         out_o
);

localparam id_pkg::id_out_t BUBBLE = '{
    pc:       BUBBLE_PC,
    ir:       id_pkg::NOP_IR,
    alu_op1:  '0,
    alu_op2:  '0,
    alu_mode: id_pkg::ALU_ADD,
    ma_mode:  id_pkg::MA_NONE,
    ma_size:  id_pkg::MA_SIZE_W,
    ma_data:  '0,
    wb_src:   id_pkg::WB_SRC_ALU,
    wb_data:  '0,
    wb_valid: 1'b0,
    halt:     1'b0
};

id_pkg::decoded_t dec_w;
id_pkg::word_t    rs1_data_w;
id_pkg::word_t    rs2_data_w;
id_pkg::word_t    ra_w;        // bypassed rs1
id_pkg::word_t    rb_w;        // bypassed rs2
id_pkg::word_t    alu_op1_w;
id_pkg::word_t    alu_op2_w;
logic             hazard_w;
id_pkg::jump_t    jmp_w;
id_pkg::id_out_t  next_w;

instr_decoder u_decoder (
    .ir_i  (ir_i),
    .dec_o (dec_w)
);

reg_file u_reg_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_i      (dec_w.rs1),
    .rs2_i      (dec_w.rs2),
    .wr_i       (wb_i),
    .rs1_data_o (rs1_data_w),
    .rs2_data_o (rs2_data_w)
);

operand_bypass u_bypass (
    .dec_i      (dec_w),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data_w),
    .rs2_data_i (rs2_data_w),
    .ex_fwd_i   (ex_fwd_i),
    .ma_fwd_i   (ma_fwd_i),
    .wb_i       (wb_i),
    .ra_o       (ra_w),
    .rb_o       (rb_w),
    .hazard_o   (hazard_w),
    .alu_op1_o  (alu_op1_w),
    .alu_op2_o  (alu_op2_w)
);

branch_unit u_branch (
    .dec_i    (dec_w),
    .pc_i     (pc_i),
    .ra_i     (ra_w),
    .rb_i     (rb_w),
    .hazard_i (hazard_w),
    .jmp_o    (jmp_w)
);

// fetch holds its inputs while ready_o is low
always_comb begin
    ready_o = reset_i || !hazard_w;
    jmp_o   = reset_i ? '0 : jmp_w;
end

always_comb begin
    next_w.pc       = pc_i;
    next_w.ir       = ir_i;
    next_w.alu_op1  = alu_op1_w;
    next_w.alu_op2  = alu_op2_w;
    next_w.alu_mode = dec_w.ctrl.alu_mode;
    next_w.ma_mode  = dec_w.ctrl.ma_mode;
    next_w.ma_size  = dec_w.ctrl.ma_size;
    next_w.ma_data  = rb_w;          // store data
    next_w.wb_src   = dec_w.ctrl.wb_src;
    next_w.wb_data  = pc_i + 32'd4;  // link address for jal/jalr
    next_w.wb_valid = (dec_w.ctrl.wb_src != id_pkg::WB_SRC_NONE) && (dec_w.rd != '0);
    next_w.halt     = dec_w.ctrl.halt;
end

// a stalled instruction leaves a bubble behind
always_ff @(posedge clk_i) begin
    if (reset_i || hazard_w) begin
        out_o <= BUBBLE;
    end else begin
        out_o <= next_w;
    end
end

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  wire id_pkg::word_t    ir_i,
    output id_pkg::decoded_t      dec_o
);

logic [6:0]        funct7_w;
logic [2:0]        funct3_w;
logic [6:0]        opcode_w;
id_pkg::alu_mode_e mode7_w;   // full funct7/funct3 mode
id_pkg::alu_mode_e mode3_w;   // funct3 only
id_pkg::ctrl_word_t cw_w;

always_comb begin
    funct7_w = ir_i[31:25];
    funct3_w = ir_i[14:12];
    opcode_w = ir_i[6:0];
    mode7_w  = id_pkg::alu_mode_e'({funct7_w[0], funct7_w[5], funct3_w});
    mode3_w  = id_pkg::alu_mode_e'({2'b00, funct3_w});
end

// control word table, defaults describe a plain op on rs1 and imm_i
always_comb begin
    cw_w.halt     = 1'b0;
    cw_w.pc_mode  = id_pkg::PC_NEXT;
    cw_w.alu_op1  = id_pkg::ALU_OP1_RS1;
    cw_w.alu_op2  = id_pkg::ALU_OP2_IMMI;
    cw_w.alu_mode = id_pkg::ALU_ADD;
    cw_w.ma_mode  = id_pkg::MA_NONE;
    cw_w.ma_size  = id_pkg::MA_SIZE_W;
    cw_w.wb_src   = id_pkg::WB_SRC_ALU;
    cw_w.ra_used  = 1'b1;
    cw_w.rb_used  = 1'b0;

    casez ({funct7_w, funct3_w, opcode_w})
        {7'b0000000, 3'b001, id_pkg::OP_IMM},
        {7'b0?00000, id_pkg::F3_SRL_SRA, id_pkg::OP_IMM}: begin
            cw_w.alu_mode = mode7_w;   // slli, srli, srai
        end
        {7'b???????, 3'b?00, id_pkg::OP_IMM},
        {7'b???????, 3'b?1?, id_pkg::OP_IMM}: begin
            cw_w.alu_mode = mode3_w;
        end
        {7'b???????, 3'b???, id_pkg::OP_LUI}: begin
            cw_w.alu_op1  = id_pkg::ALU_OP1_IMMU;
            cw_w.alu_op2  = id_pkg::ALU_OP2_ZERO;
            cw_w.alu_mode = id_pkg::ALU_COPY1;
            cw_w.ra_used  = 1'b0;
        end
        {7'b???????, 3'b???, id_pkg::OP_AUIPC}: begin
            cw_w.alu_op1 = id_pkg::ALU_OP1_IMMU;
            cw_w.alu_op2 = id_pkg::ALU_OP2_PC;
            cw_w.ra_used = 1'b0;
        end
        {7'b0000000, 3'b???, id_pkg::OP},
        {7'b0100000, 3'b000, id_pkg::OP},
        {7'b0100000, id_pkg::F3_SRL_SRA, id_pkg::OP}: begin
            cw_w.alu_op2  = id_pkg::ALU_OP2_RS2;
            cw_w.alu_mode = mode7_w;
            cw_w.rb_used  = 1'b1;
        end
        {7'b???????, 3'b???, id_pkg::OP_JAL}: begin
            cw_w.pc_mode = id_pkg::PC_JUMP_REL;
            cw_w.alu_op1 = id_pkg::ALU_OP1_ZERO;
            cw_w.alu_op2 = id_pkg::ALU_OP2_ZERO;
            cw_w.wb_src  = id_pkg::WB_SRC_PC4;
            cw_w.ra_used = 1'b0;
        end
        {7'b???????, 3'b000, id_pkg::OP_JALR}: begin
            cw_w.pc_mode = id_pkg::PC_JUMP_ABS;
            cw_w.alu_op1 = id_pkg::ALU_OP1_ZERO;
            cw_w.alu_op2 = id_pkg::ALU_OP2_ZERO;
            cw_w.wb_src  = id_pkg::WB_SRC_PC4;
        end
        {7'b???????, id_pkg::F3_BEQ,  id_pkg::OP_BRANCH},
        {7'b???????, id_pkg::F3_BNE,  id_pkg::OP_BRANCH},
        {7'b???????, id_pkg::F3_BLT,  id_pkg::OP_BRANCH},
        {7'b???????, id_pkg::F3_BGE,  id_pkg::OP_BRANCH},
        {7'b???????, id_pkg::F3_BLTU, id_pkg::OP_BRANCH},
        {7'b???????, id_pkg::F3_BGEU, id_pkg::OP_BRANCH}: begin
            cw_w.pc_mode = id_pkg::PC_BRANCH;
            cw_w.alu_op1 = id_pkg::ALU_OP1_ZERO;
            cw_w.alu_op2 = id_pkg::ALU_OP2_ZERO;
            cw_w.wb_src  = id_pkg::WB_SRC_NONE;
            cw_w.rb_used = 1'b1;
        end
        {7'b???????, 3'b00?, id_pkg::OP_LOAD},
        {7'b???????, 3'b010, id_pkg::OP_LOAD},
        {7'b???????, 3'b10?, id_pkg::OP_LOAD}: begin
            cw_w.ma_mode = id_pkg::MA_LOAD;
            cw_w.ma_size = id_pkg::ma_size_e'(funct3_w);
            cw_w.wb_src  = id_pkg::WB_SRC_MEM;
        end
        {7'b???????, 3'b00?, id_pkg::OP_STORE},
        {7'b???????, 3'b010, id_pkg::OP_STORE}: begin
            cw_w.alu_op2 = id_pkg::ALU_OP2_IMMS;
            cw_w.ma_mode = id_pkg::MA_STORE;
            cw_w.ma_size = id_pkg::ma_size_e'(funct3_w);
            cw_w.wb_src  = id_pkg::WB_SRC_NONE;
            cw_w.rb_used = 1'b1;
        end
        {7'b???????, 3'b???, id_pkg::OP_MISC_MEM}: begin   // fence runs as a nop
            cw_w.alu_op1 = id_pkg::ALU_OP1_ZERO;
            cw_w.alu_op2 = id_pkg::ALU_OP2_ZERO;
            cw_w.wb_src  = id_pkg::WB_SRC_NONE;
            cw_w.ra_used = 1'b0;
        end
        default: begin
            cw_w.halt    = 1'b1;   // illegal, includes SYSTEM
            cw_w.wb_src  = id_pkg::WB_SRC_NONE;
            cw_w.ra_used = 1'b0;
        end
    endcase
end

always_comb begin
    dec_o.ctrl   = cw_w;
    dec_o.rs1    = ir_i[19:15];
    dec_o.rs2    = ir_i[24:20];
    dec_o.rd     = ir_i[11:7];
    dec_o.funct3 = funct3_w;
    dec_o.imm_i  = {{20{ir_i[31]}}, ir_i[31:20]};
    dec_o.imm_s  = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    dec_o.imm_b  = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    dec_o.imm_u  = {ir_i[31:12], 12'b0};
    dec_o.imm_j  = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
end

endmodule

`default_nettype wire

// File: logic/operand_bypass.sv
`default_nettype none

module operand_bypass (
    input  wire id_pkg::decoded_t   dec_i,
    input  wire id_pkg::word_t      pc_i,
    input  wire id_pkg::word_t      rs1_data_i,
    input  wire id_pkg::word_t      rs2_data_i,
    input  wire id_pkg::fwd_t       ex_fwd_i,
    input  wire id_pkg::fwd_t       ma_fwd_i,
    input  wire id_pkg::reg_write_t wb_i,
    output id_pkg::word_t           ra_o,
    output id_pkg::word_t           rb_o,
    output logic                    hazard_o,
    output id_pkg::word_t           alu_op1_o,
    output id_pkg::word_t           alu_op2_o
);

// youngest matching result wins
function automatic id_pkg::word_t bypass(id_pkg::regaddr_t rs, id_pkg::word_t rf_data);
    id_pkg::word_t val;
    if (rs == '0)
        val = '0;
    else if (ex_fwd_i.wr.valid && ex_fwd_i.wr.addr == rs)
        val = ex_fwd_i.wr.data;
    else if (ma_fwd_i.wr.valid && ma_fwd_i.wr.addr == rs)
        val = ma_fwd_i.wr.data;
    else if (wb_i.valid && wb_i.addr == rs)
        val = wb_i.data;
    else
        val = rf_data;
    return val;
endfunction

// a pending result that is not computed yet
function automatic logic collide(id_pkg::regaddr_t rs, logic used);
    logic ex_hit;
    logic ma_hit;
    ex_hit = ex_fwd_i.wr.valid && !ex_fwd_i.ready && ex_fwd_i.wr.addr == rs;
    ma_hit = ma_fwd_i.wr.valid && !ma_fwd_i.ready && ma_fwd_i.wr.addr == rs;
    return used && (rs != '0) && (ex_hit || ma_hit);
endfunction

always_comb begin
    ra_o     = bypass(dec_i.rs1, rs1_data_i);
    rb_o     = bypass(dec_i.rs2, rs2_data_i);
    hazard_o = collide(dec_i.rs1, dec_i.ctrl.ra_used)
            || collide(dec_i.rs2, dec_i.ctrl.rb_used);
end

always_comb begin
    case (dec_i.ctrl.alu_op1)
        id_pkg::ALU_OP1_RS1:  alu_op1_o = ra_o;
        id_pkg::ALU_OP1_IMMU: alu_op1_o = dec_i.imm_u;
        default:              alu_op1_o = '0;
    endcase

    case (dec_i.ctrl.alu_op2)
        id_pkg::ALU_OP2_RS2:  alu_op2_o = rb_o;
        id_pkg::ALU_OP2_IMMI: alu_op2_o = dec_i.imm_i;
        id_pkg::ALU_OP2_IMMS: alu_op2_o = dec_i.imm_s;
        id_pkg::ALU_OP2_PC:   alu_op2_o = pc_i;   // auipc
        default:              alu_op2_o = '0;
    endcase
end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire id_pkg::regaddr_t   rs1_i,
    input  wire id_pkg::regaddr_t   rs2_i,
    input  wire id_pkg::reg_write_t wr_i,
    output id_pkg::word_t           rs1_data_o,
    output id_pkg::word_t           rs2_data_o
);

// x0 has no storage
id_pkg::word_t regs_r [31:1];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int i = 1; i < 32; i++) begin
            regs_r[i] <= '0;
        end
    end else if (wr_i.valid && wr_i.addr != '0) begin
        regs_r[wr_i.addr] <= wr_i.data;
    end
end

// reads see the old value during a write, wb bypass covers that case
always_comb begin
    rs1_data_o = (rs1_i == '0) ? '0 : regs_r[rs1_i];
    rs2_data_o = (rs2_i == '0) ? '0 : regs_r[rs2_i];
end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module id_stage_tb -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/Vid_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: verification/id_stage_tb.sv
`default_nettype none

module id_stage_tb;

timeunit 1ns;
timeprecision 1ps;

localparam id_pkg::word_t BUBBLE_PC = 32'h0000_0ffc;
// one cycle per step of reset, decode, bypass, hazard, jumps and illegal
localparam int TEST_CYCLES = 5 + 11 + 5 + 5 + 16 + 3;
localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

logic               clk_i;
logic               reset_i;
id_pkg::word_t      pc_i;
id_pkg::word_t      ir_i;
id_pkg::fwd_t       ex_fwd_i;
id_pkg::fwd_t       ma_fwd_i;
id_pkg::reg_write_t wb_i;
logic               ready_o;
id_pkg::jump_t      jmp_o;
id_pkg::id_out_t    out_o;

id_pkg::word_t shadow [32];   // expected register file contents
int            errors;
int            checks;
int            tests;
int            cycle_count;
integer        seed;

id_stage #(.BUBBLE_PC(BUBBLE_PC)) DUT (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .pc_i     (pc_i),
    .ir_i     (ir_i),
    .ex_fwd_i (ex_fwd_i),
    .ma_fwd_i (ma_fwd_i),
    .wb_i     (wb_i),
    .ready_o  (ready_o),
    .jmp_o    (jmp_o),
    .out_o    (out_o)
);

initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
end

// fetch must never be held off or redirected while in reset
assert property (@(posedge clk_i) reset_i |-> (ready_o && !jmp_o.valid))
    else begin
        errors++;
        $display("Fail at %0d ns: ready_o is %b, expected 1; jmp_o.valid is %b, expected 0",
                 $time, ready_o, jmp_o.valid);
    end

function automatic id_pkg::word_t r_type(input logic [6:0] f7, input id_pkg::regaddr_t rs2,
        input id_pkg::regaddr_t rs1, input logic [2:0] f3, input id_pkg::regaddr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic id_pkg::word_t i_type(input logic [11:0] imm, input id_pkg::regaddr_t rs1,
        input logic [2:0] f3, input id_pkg::regaddr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic id_pkg::word_t s_type(input logic [11:0] imm, input id_pkg::regaddr_t rs2,
        input id_pkg::regaddr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic id_pkg::word_t b_type(input logic [12:0] imm, input id_pkg::regaddr_t rs2,
        input id_pkg::regaddr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic id_pkg::word_t u_type(input logic [19:0] imm, input id_pkg::regaddr_t rd,
        input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic id_pkg::word_t j_type(input logic [20:0] imm, input id_pkg::regaddr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic id_pkg::fwd_t in_flight(input logic valid, input id_pkg::regaddr_t addr,
        input id_pkg::word_t data, input logic ready);
    id_pkg::fwd_t f;
    f.wr.valid = valid;
    f.wr.addr  = addr;
    f.wr.data  = data;
    f.ready    = ready;
    return f;
endfunction

function automatic id_pkg::reg_write_t retired(input logic valid, input id_pkg::regaddr_t addr,
        input id_pkg::word_t data);
    id_pkg::reg_write_t w;
    w.valid = valid;
    w.addr  = addr;
    w.data  = data;
    return w;
endfunction

function automatic id_pkg::id_out_t bubble_out();
    id_pkg::id_out_t o;
    o          = '0;
    o.pc       = BUBBLE_PC;
    o.ir       = id_pkg::NOP_IR;
    o.alu_mode = id_pkg::ALU_ADD;
    o.ma_mode  = id_pkg::MA_NONE;
    o.ma_size  = id_pkg::MA_SIZE_W;
    o.wb_src   = id_pkg::WB_SRC_ALU;
    return o;
endfunction

// ex before ma before wb before the register file
function automatic id_pkg::word_t source_value(input id_pkg::regaddr_t r);
    if (r == 5'd0)
        return '0;
    if (ex_fwd_i.wr.valid && ex_fwd_i.wr.addr == r)
        return ex_fwd_i.wr.data;
    if (ma_fwd_i.wr.valid && ma_fwd_i.wr.addr == r)
        return ma_fwd_i.wr.data;
    if (wb_i.valid && wb_i.addr == r)
        return wb_i.data;
    return shadow[r];
endfunction

function automatic logic pending_write(input id_pkg::regaddr_t r);
    logic ex_hit;
    logic ma_hit;
    ex_hit = ex_fwd_i.wr.valid && !ex_fwd_i.ready && ex_fwd_i.wr.addr == r;
    ma_hit = ma_fwd_i.wr.valid && !ma_fwd_i.ready && ma_fwd_i.wr.addr == r;
    return (r != 5'd0) && (ex_hit || ma_hit);
endfunction

// reference decode straight from the RV32I encodings
function automatic void predict(input id_pkg::word_t pc, input id_pkg::word_t ir,
        output id_pkg::id_out_t o, output id_pkg::jump_t j, output logic hz);
    logic [6:0]       opc;
    logic [6:0]       f7;
    logic [2:0]       f3;
    id_pkg::regaddr_t rs1;
    id_pkg::regaddr_t rs2;
    id_pkg::word_t    imm_i;
    id_pkg::word_t    a;
    id_pkg::word_t    b;
    logic             use_a;
    logic             use_b;
    logic             take;
    opc   = ir[6:0];
    f3    = ir[14:12];
    f7    = ir[31:25];
    rs1   = ir[19:15];
    rs2   = ir[24:20];
    imm_i = {{20{ir[31]}}, ir[31:20]};
    a     = source_value(rs1);
    b     = source_value(rs2);
    use_a = 1'b1;
    use_b = 1'b0;
    j     = '0;
    o          = '0;
    o.pc       = pc;
    o.ir       = ir;
    o.alu_op1  = a;
    o.alu_op2  = imm_i;
    o.alu_mode = id_pkg::ALU_ADD;
    o.ma_mode  = id_pkg::MA_NONE;
    o.ma_size  = id_pkg::MA_SIZE_W;
    o.ma_data  = b;               // store data is always the bypassed rs2
    o.wb_src   = id_pkg::WB_SRC_ALU;
    o.wb_data  = pc + 32'd4;
    case (opc)
        7'b0010011: begin   // op-imm
            if (f3 == 3'b001) begin
                o.alu_mode = id_pkg::ALU_SLL;
                o.halt     = (f7 != 7'h00);
            end else if (f3 == 3'b101) begin
                if (f7 == 7'h00)
                    o.alu_mode = id_pkg::ALU_SRL;
                else if (f7 == 7'h20)
                    o.alu_mode = id_pkg::ALU_SRA;
                else
                    o.halt = 1'b1;
            end else begin
                o.alu_mode = id_pkg::alu_mode_e'({2'b00, f3});
            end
        end
        7'b0110111, 7'b0010111: begin   // lui and auipc
            o.alu_op1 = {ir[31:12], 12'h000};
            use_a     = 1'b0;
            if (opc[5]) begin
                o.alu_op2  = '0;
                o.alu_mode = id_pkg::ALU_COPY1;
            end else begin
                o.alu_op2 = pc;
            end
        end
        7'b0110011: begin
            o.alu_op2 = b;
            use_b     = 1'b1;
            if (f7 == 7'h00)
                o.alu_mode = id_pkg::alu_mode_e'({2'b00, f3});
            else if (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))
                o.alu_mode = id_pkg::alu_mode_e'({2'b01, f3});
            else
                o.halt = 1'b1;
        end
        7'b1101111: begin   // jal
            o.alu_op1 = '0;
            o.alu_op2 = '0;
            o.wb_src  = id_pkg::WB_SRC_PC4;
            use_a     = 1'b0;
            j.valid   = 1'b1;
            j.addr    = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        end
        7'b1100111: begin   // jalr
            o.alu_op1 = '0;
            o.alu_op2 = '0;
            o.wb_src  = id_pkg::WB_SRC_PC4;
            o.halt    = (f3 != 3'b000);
            j.valid   = 1'b1;
            j.addr    = a + imm_i;
        end
        7'b1100011: begin
            o.alu_op1 = '0;
            o.alu_op2 = '0;
            o.wb_src  = id_pkg::WB_SRC_NONE;
            use_b     = 1'b1;
            case (f3)
                3'b000:  take = (a == b);
                3'b001:  take = (a != b);
                3'b100:  take = ($signed(a) < $signed(b));
                3'b101:  take = ($signed(a) >= $signed(b));
                3'b110:  take = (a < b);
                3'b111:  take = (a >= b);
                default: begin
                    take   = 1'b0;
                    o.halt = 1'b1;
                end
            endcase
            j.valid = take;
            j.addr  = pc + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
        end
        7'b0000011: begin   // loads
            o.ma_mode = id_pkg::MA_LOAD;
            o.ma_size = id_pkg::ma_size_e'(f3);
            o.wb_src  = id_pkg::WB_SRC_MEM;
            o.halt    = (f3 == 3'b011) || (f3 > 3'b101);
        end
        7'b0100011: begin   // stores
            o.alu_op2 = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            o.ma_mode = id_pkg::MA_STORE;
            o.ma_size = id_pkg::ma_size_e'(f3);
            o.wb_src  = id_pkg::WB_SRC_NONE;
            o.halt    = (f3 > 3'b010);
            use_b     = 1'b1;
        end
        7'b0001111: begin   // fence does nothing
            o.alu_op1 = '0;
            o.alu_op2 = '0;
            o.wb_src  = id_pkg::WB_SRC_NONE;
            use_a     = 1'b0;
        end
        default: o.halt = 1'b1;
    endcase
    if (o.halt) begin
        o.wb_src = id_pkg::WB_SRC_NONE;
        use_a    = 1'b0;
        use_b    = 1'b0;
        j        = '0;
    end
    o.wb_valid = (o.wb_src != id_pkg::WB_SRC_NONE) && (ir[11:7] != 5'd0);
    hz = (use_a && pending_write(rs1)) || (use_b && pending_write(rs2));
    if (hz) begin
        o       = bubble_out();
        j.valid = 1'b0;
    end
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want)
        else begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, want);
        end
endtask

task automatic compare_out(input id_pkg::id_out_t want);
    check("out_o.pc", out_o.pc, want.pc);
    check("out_o.ir", out_o.ir, want.ir);
    check("out_o.halt", out_o.halt, want.halt);
    if (!want.halt) begin
        check("out_o.alu_op1", out_o.alu_op1, want.alu_op1);
        check("out_o.alu_op2", out_o.alu_op2, want.alu_op2);
        check("out_o.alu_mode", out_o.alu_mode, want.alu_mode);
        check("out_o.ma_mode", out_o.ma_mode, want.ma_mode);
        check("out_o.ma_data", out_o.ma_data, want.ma_data);
        check("out_o.wb_src", out_o.wb_src, want.wb_src);
        check("out_o.wb_data", out_o.wb_data, want.wb_data);
        check("out_o.wb_valid", out_o.wb_valid, want.wb_valid);
        if (want.ma_mode != id_pkg::MA_NONE)
            check("out_o.ma_size", out_o.ma_size, want.ma_size);
    end
endtask

// called 1 ns after an edge and returns 1 ns after the next one
task automatic step(input id_pkg::word_t pc, input id_pkg::word_t ir);
    id_pkg::id_out_t want;
    id_pkg::jump_t   want_jmp;
    logic            want_stall;
    pc_i = pc;
    ir_i = ir;
    #2;   // combinational paths settled
    predict(pc, ir, want, want_jmp, want_stall);
    check("ready_o", ready_o, !want_stall);
    check("jmp_o.valid", jmp_o.valid, want_jmp.valid);
    if (want_jmp.valid)
        check("jmp_o.addr", jmp_o.addr, want_jmp.addr);
    @(posedge clk_i);
    if (wb_i.valid && wb_i.addr != 5'd0)
        shadow[wb_i.addr] = wb_i.data;
    #1;
    compare_out(want);
endtask

task automatic load_reg(input id_pkg::regaddr_t addr, input id_pkg::word_t data);
    wb_i = retired(1'b1, addr, data);
    step(32'h0000_0100, id_pkg::NOP_IR);
    wb_i = '0;
endtask

task automatic end_test(input string name, input int mark);
    tests++;
    $display("%s: finished with %0d errors", name, errors - mark);
endtask

initial begin
    int mark;
    id_pkg::regaddr_t rs2_sel;
    seed     = 32'h5df4;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    reset_i  = 1'b1;
    pc_i     = '0;
    ir_i     = j_type(21'h000100, 5'd1);   // jal would redirect outside reset
    ex_fwd_i = '0;
    ma_fwd_i = '0;
    wb_i     = '0;
    for (int i = 0; i < 32; i++) begin
        shadow[i] = '0;
    end

    mark = errors;
    for (int i = 0; i < 4; i++) begin
        @(posedge clk_i);
        #1;
        compare_out(bubble_out());
        check("ready_o", ready_o, 1'b1);
        check("jmp_o.valid", jmp_o.valid, 1'b0);
        if (i == 1) begin   // a pending rs2 would stall outside reset
            ir_i     = r_type(7'h00, 5'd5, 5'd1, 3'b000, 5'd14);
            ex_fwd_i = in_flight(1'b1, 5'd5, 32'h0505_0505, 1'b0);
        end
    end
    reset_i  = 1'b0;
    ir_i     = id_pkg::NOP_IR;
    ex_fwd_i = '0;
    #2;
    compare_out(bubble_out());   // bubble still held right after release
    check("ready_o", ready_o, 1'b1);
    check("jmp_o.valid", jmp_o.valid, 1'b0);
    @(posedge clk_i);
    #1;
    end_test("reset", mark);

    mark = errors;
    load_reg(5'd1, $random(seed));
    load_reg(5'd2, $random(seed));
    load_reg(5'd3, $random(seed));
    step(32'h0000_0200, i_type(12'hff9, 5'd1, 3'b000, 5'd5, 7'b0010011));          // addi
    step(32'h0000_0204, i_type({7'h20, 5'd3}, 5'd2, 3'b101, 5'd6, 7'b0010011));    // srai
    step(32'h0000_0208, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd7));                  // sub
    step(32'h0000_020c, u_type(20'h12345, 5'd8, 7'b0110111));                      // lui
    step(32'h0000_0210, u_type(20'habcde, 5'd9, 7'b0010111));                      // auipc
    step(32'h0000_0214, i_type(12'h010, 5'd3, 3'b010, 5'd10, 7'b0000011));         // lw
    step(32'h0000_0218, s_type(12'hffc, 5'd2, 5'd3, 3'b010));                      // sw
    step(32'h0000_021c, i_type(12'h001, 5'd1, 3'b000, 5'd0, 7'b0010011));          // rd = x0
    end_test("decode", mark);

    mark = errors;
    ex_fwd_i = in_flight(1'b1, 5'd4, 32'h1111_1111, 1'b1);
    ma_fwd_i = in_flight(1'b1, 5'd4, 32'h2222_2222, 1'b1);
    wb_i     = retired(1'b1, 5'd4, 32'h3333_3333);
    step(32'h0000_0300, r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd12));
    ex_fwd_i.wr.valid = 1'b0;
    wb_i.data         = 32'h4444_4444;
    step(32'h0000_0304, r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd12));
    ma_fwd_i.wr.valid = 1'b0;
    wb_i.data         = 32'h5555_5555;   // differs from what x4 holds now
    step(32'h0000_0308, r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd12));
    wb_i = '0;
    step(32'h0000_030c, r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd12));
    ex_fwd_i = in_flight(1'b1, 5'd0, 32'hdead_0001, 1'b1);
    ma_fwd_i = in_flight(1'b1, 5'd0, 32'hdead_0002, 1'b1);
    wb_i     = retired(1'b1, 5'd0, 32'hdead_0003);
    step(32'h0000_0310, r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd13));
    ex_fwd_i = '0;
    ma_fwd_i = '0;
    wb_i     = '0;
    end_test("bypass", mark);

    mark = errors;
    ex_fwd_i = in_flight(1'b1, 5'd5, 32'h0505_0505, 1'b0);
    step(32'h0000_0400, r_type(7'h00, 5'd5, 5'd1, 3'b000, 5'd14));   // stalls on rs2
    ex_fwd_i.ready = 1'b1;
    step(32'h0000_0400, r_type(7'h00, 5'd5, 5'd1, 3'b000, 5'd14));   // same instr goes through
    ex_fwd_i = '0;
    ma_fwd_i = in_flight(1'b1, 5'd3, 32'h0000_8000, 1'b0);
    step(32'h0000_0404, i_type(12'h008, 5'd3, 3'b000, 5'd1, 7'b1100111));
    ma_fwd_i.ready = 1'b1;
    step(32'h0000_0404, i_type(12'h008, 5'd3, 3'b000, 5'd1, 7'b1100111));
    ma_fwd_i = '0;
    ex_fwd_i = in_flight(1'b1, 5'd5, 32'h0505_0505, 1'b0);
    step(32'h0000_0408, i_type(12'h005, 5'd6, 3'b000, 5'd15, 7'b0010011));   // rs2 field unused
    ex_fwd_i = '0;
    end_test("hazard", mark);

    mark = errors;
    step(32'h0000_0500, j_type(21'h000100, 5'd1));
    step(32'h0000_0504, i_type(12'h00c, 5'd3, 3'b000, 5'd2, 7'b1100111));
    load_reg(5'd20, $random(seed));
    load_reg(5'd21, $random(seed));
    for (int round = 0; round < 2; round++) begin
        rs2_sel = (round == 0) ? 5'd21 : 5'd20;   // second round compares equal values
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3)
                step(32'h0000_0600, b_type(round == 0 ? 13'h1ff8 : 13'h0040,
                                           rs2_sel, 5'd20, k[2:0]));
        end
    end
    end_test("jumps", mark);

    mark = errors;
    step(32'h0000_0700, 32'h0000_0073);   // ecall
    step(32'h0000_0704, 32'h0000_007f);   // no such opcode
    step(32'h0000_0708, 32'h0ff0_000f);   // fence
    end_test("illegal", mark);

    $display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
        @(posedge clk_i);
        cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
end

endmodule

`default_nettype wire
